//--- Makefile
SIM      = verilator
FLAGS    = --binary --assert --timing -j 0
TOP      = sram_axi_tb
FILELIST = compile.f
OBJ_DIR  = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf $(OBJ_DIR)

//--- compile.f
+incdir+.
sram_axi_pkg.sv
sram_axi_burst_addr.sv
sram_axi_ctrl.sv
sram_axi_read_port.sv
sram_axi_write_port.sv
sram_axi_mem.sv
sram_axi_top.sv
sram_axi_checker.sv
sram_axi_tb.sv

//--- sram_axi_burst_addr.sv
/*
 * Burst address generator
 * Steps a word index through a FIXED, INCR or WRAP burst and flags the last beat
 */
`timescale 1ns/1ps
`include "sram_axi_consts.svh"

module sram_axi_burst_addr (
    input  logic                 i_aclk,
    input  logic                 i_areset_n,
    input  logic                 i_load,
    input  sram_axi_pkg::addr_t  i_start,
    input  sram_axi_pkg::len_t   i_len,
    input  sram_axi_pkg::burst_t i_burst,
    input  logic                 i_step,
    output sram_axi_pkg::idx_t   o_idx,
    output logic                 o_last
);
    import sram_axi_pkg::*;

    addr_t  r_addr;
    addr_t  r_mask;
    len_t   r_len;
    len_t   r_cnt;
    burst_t r_burst;
    logic   w_wrap_ok;
    addr_t  w_win_mask;
    addr_t  w_next;

    // Only 2, 4, 8 and 16 beat WRAP bursts get a window
    assign w_wrap_ok  = (i_burst == BURST_WRAP) &&
                        (i_len == 8'd1 || i_len == 8'd3 || i_len == 8'd7 || i_len == 8'd15);
    assign w_win_mask = {{(`SRAM_ADDR_W-4-`SRAM_BYTE_OFFS){1'b0}}, i_len[3:0],
                         {`SRAM_BYTE_OFFS{1'b1}}};

    // Upper bits stay, offset inside the window advances by one beat
    assign w_next = (r_addr & ~r_mask) | ((r_addr + addr_t'(`SRAM_BEAT_BYTES)) & r_mask);

    always_ff @(posedge i_aclk) begin
        if (!i_areset_n) begin
            r_cnt   <= '0;
            r_len   <= '0;
            r_burst <= BURST_INCR;
        end
        else if (i_load) begin
            r_cnt   <= '0;
            r_len   <= i_len;
            r_burst <= i_burst;
        end
        else if (i_step) begin
            r_cnt <= r_cnt + 8'd1;
        end
    end

    always_ff @(posedge i_aclk) begin
        if (i_load) begin
            r_addr <= {i_start[`SRAM_ADDR_W-1:`SRAM_BYTE_OFFS], {`SRAM_BYTE_OFFS{1'b0}}};
            // INCR spans the whole 2 KB space
            r_mask <= w_wrap_ok ? w_win_mask : '1;
        end
        else if (i_step && (r_burst == BURST_INCR || r_burst == BURST_WRAP)) begin
            r_addr <= w_next;
        end
    end

    assign o_idx  = r_addr[`SRAM_ADDR_W-1:`SRAM_BYTE_OFFS];
    assign o_last = (r_cnt == r_len);

endmodule

//--- sram_axi_checker.sv
/*
 * AXI protocol checker for the SRAM slave
 * Bound to the top level, flags channel hold and ordering faults
 */
`timescale 1ns/1ps

module sram_axi_checker (
    input logic                i_aclk,
    input logic                i_areset_n,
    input logic                i_arvalid,
    input logic                i_awready,
    input logic                i_rvalid,
    input logic                i_rready,
    input sram_axi_pkg::data_t i_rdata,
    input logic                i_rlast,
    input logic                i_wready,
    input logic                i_bvalid,
    input logic                i_bready
);
    import sram_axi_pkg::*;

    int fail_cnt = 0;

    // Stalled R beat keeps its payload
    a_r_hold: assert property (@(posedge i_aclk) disable iff (!i_areset_n)
        (i_rvalid && !i_rready) |=> (i_rvalid && $stable(i_rdata) && $stable(i_rlast)))
        else begin
            $error("R beat changed before it was taken");
            fail_cnt++;
        end

    a_b_hold: assert property (@(posedge i_aclk) disable iff (!i_areset_n)
        (i_bvalid && !i_bready) |=> i_bvalid)
        else begin
            $error("B response dropped before it was taken");
            fail_cnt++;
        end

    // One transaction in flight
    a_one_dir: assert property (@(posedge i_aclk) disable iff (!i_areset_n)
        !(i_wready && i_rvalid))
        else begin
            $error("Write data and read data channels active together");
            fail_cnt++;
        end

    a_rd_first: assert property (@(posedge i_aclk) disable iff (!i_areset_n)
        i_arvalid |-> !i_awready)
        else begin
            $error("AW accepted while a read address was pending");
            fail_cnt++;
        end

endmodule

//--- sram_axi_consts.svh
/*
 * SRAM AXI4 slave constants
 * Data and address widths, memory depth and burst geometry
 */
`ifndef SRAM_AXI_CONSTS_SVH
`define SRAM_AXI_CONSTS_SVH

`define SRAM_DATA_W     64
`define SRAM_ADDR_W     11
`define SRAM_DEPTH      256
`define SRAM_LEN_W      8
`define SRAM_BYTE_OFFS  3
`define SRAM_BEAT_BYTES 8

`endif

//--- sram_axi_ctrl.sv
/*
 * Transaction controller
 * Accepts one read or write address at a time, reads win ties
 */
`timescale 1ns/1ps

module sram_axi_ctrl (
    input  logic i_aclk,
    input  logic i_areset_n,
    input  logic i_arvalid,
    input  logic i_awvalid,
    input  logic i_rd_done,
    input  logic i_wr_done,
    output logic o_arready,
    output logic o_awready,
    output logic o_rd_start,
    output logic o_wr_start
);
    import sram_axi_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_READ  = 2'd1,
        ST_WRITE = 2'd2
    } state_t;

    state_t r_state;

    // Address channels open only when nothing is in flight
    assign o_arready  = (r_state == ST_IDLE);
    assign o_awready  = (r_state == ST_IDLE) && !i_arvalid;
    assign o_rd_start = i_arvalid && o_arready;
    assign o_wr_start = i_awvalid && o_awready;

    always_ff @(posedge i_aclk) begin
        if (!i_areset_n) begin
            r_state <= ST_IDLE;
        end
        else begin
            case (r_state)
                ST_IDLE: begin
                    if (o_rd_start) begin
                        r_state <= ST_READ;
                    end
                    else if (o_wr_start) begin
                        r_state <= ST_WRITE;
                    end
                end
                ST_READ: begin
                    if (i_rd_done) begin
                        r_state <= ST_IDLE;
                    end
                end
                ST_WRITE: begin
                    if (i_wr_done) begin
                        r_state <= ST_IDLE;
                    end
                end
                default: begin
                    r_state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

//--- sram_axi_mem.sv
/*
 * SRAM storage, 256 words of 64 bits
 * Byte-enabled writes, registered reads, index pattern loaded on reset
 */
`timescale 1ns/1ps
`include "sram_axi_consts.svh"

module sram_axi_mem (
    input  logic                i_aclk,
    input  logic                i_areset_n,
    input  logic                i_rd_en,
    input  sram_axi_pkg::idx_t  i_rd_idx,
    output sram_axi_pkg::data_t o_rd_data,
    input  logic                i_wr_en,
    input  sram_axi_pkg::idx_t  i_wr_idx,
    input  sram_axi_pkg::data_t i_wr_data,
    input  sram_axi_pkg::strb_t i_wr_strb
);
    import sram_axi_pkg::*;

    data_t r_ram [`SRAM_DEPTH];

    always_ff @(posedge i_aclk) begin
        if (!i_areset_n) begin
            // Each word starts as its own index
            for (int i = 0; i < `SRAM_DEPTH; i++) begin
                r_ram[i] <= data_t'(idx_t'(i));
            end
        end
        else if (i_wr_en) begin
            for (int b = 0; b < `SRAM_BEAT_BYTES; b++) begin
                if (i_wr_strb[b]) begin
                    r_ram[i_wr_idx][b*8 +: 8] <= i_wr_data[b*8 +: 8];
                end
            end
        end
    end

    // Output holds while no read is issued
    always_ff @(posedge i_aclk) begin
        if (i_rd_en) begin
            o_rd_data <= r_ram[i_rd_idx];
        end
    end

endmodule

//--- sram_axi_pkg.sv
/*
 * SRAM AXI4 slave package
 * Shared address, data, strobe, length and burst types
 */
`include "sram_axi_consts.svh"

package sram_axi_pkg;

    typedef logic [`SRAM_ADDR_W-1:0]                 addr_t;
    typedef logic [`SRAM_ADDR_W-`SRAM_BYTE_OFFS-1:0] idx_t;
    typedef logic [`SRAM_DATA_W-1:0]                 data_t;
    typedef logic [`SRAM_BEAT_BYTES-1:0]             strb_t;
    typedef logic [`SRAM_LEN_W-1:0]                  len_t;

    // AXI4 burst encoding, reserved code acts as FIXED
    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10,
        BURST_RSVD  = 2'b11
    } burst_t;

endpackage

//--- sram_axi_read_port.sv
/*
 * Read port
 * Sequences read bursts, issues memory reads and drives the R channel
 */
`timescale 1ns/1ps

module sram_axi_read_port (
    input  logic                 i_aclk,
    input  logic                 i_areset_n,
    input  logic                 i_rd_start,
    input  sram_axi_pkg::addr_t  i_araddr,
    input  sram_axi_pkg::len_t   i_arlen,
    input  sram_axi_pkg::burst_t i_arburst,
    input  logic                 i_rready,
    output logic                 o_rvalid,
    output logic                 o_rlast,
    output logic                 o_rd_done,
    output logic                 o_mem_rd_en,
    output sram_axi_pkg::idx_t   o_mem_rd_idx
);
    import sram_axi_pkg::*;

    logic r_active;
    logic r_rvalid;
    logic r_rlast;
    logic w_issue;
    logic w_rshake;
    logic w_last;

    assign w_rshake = r_rvalid && i_rready;

    // Next read goes out when the R register is empty or being taken
    assign w_issue = r_active && (!r_rvalid || i_rready);

    sram_axi_burst_addr rd_addr_i (
        .i_aclk     (i_aclk),
        .i_areset_n (i_areset_n),
        .i_load     (i_rd_start),
        .i_start    (i_araddr),
        .i_len      (i_arlen),
        .i_burst    (i_arburst),
        .i_step     (w_issue),
        .o_idx      (o_mem_rd_idx),
        .o_last     (w_last)
    );

    // ====================
    // Issue and delivery
    // ====================
    // r_rvalid marks the one beat issued and not yet delivered
    always_ff @(posedge i_aclk) begin
        if (!i_areset_n) begin
            r_active <= 1'b0;
            r_rvalid <= 1'b0;
            r_rlast  <= 1'b0;
        end
        else begin
            if (i_rd_start) begin
                r_active <= 1'b1;
            end
            else if (w_issue && w_last) begin
                r_active <= 1'b0;
            end

            if (w_issue) begin
                r_rvalid <= 1'b1;
                r_rlast  <= w_last;
            end
            else if (w_rshake) begin
                r_rvalid <= 1'b0;
                r_rlast  <= 1'b0;
            end
        end
    end

    assign o_mem_rd_en = w_issue;
    assign o_rvalid    = r_rvalid;
    assign o_rlast     = r_rlast;
    assign o_rd_done   = w_rshake && r_rlast;

endmodule

//--- sram_axi_stim.txt
# op addr(hex) len burst(0 fixed, 1 incr, 2 wrap) strb(hex) rready_stall bready_stall wvalid_stall
# op R read, W write, X read and write raised together; stall columns in eighths, 0 to 7
R 000 7 1 ff 0 0 0
R 7c0 15 1 ff 0 0 0
W 100 3 1 ff 0 0 0
R 100 3 1 ff 0 0 0
W 7e0 7 1 ff 0 0 0
R 7e0 7 1 ff 0 0 0
W 100 3 1 0f 0 0 0
R 100 3 1 ff 0 0 0
W 200 1 1 a5 0 0 0
R 1f8 3 1 ff 0 0 0
W 300 3 0 3c 0 0 0
R 300 3 0 ff 0 0 0
R 2f8 2 1 ff 0 0 0
W 328 1 2 ff 0 0 0
R 320 1 1 ff 0 0 0
R 328 1 2 ff 0 0 0
W 450 3 2 ff 0 0 0
R 440 3 1 ff 0 0 0
W 528 7 2 ff 0 0 0
R 510 7 2 ff 0 0 0
W 5a8 15 2 ff 0 0 0
R 580 15 1 ff 0 0 0
R 5f0 15 2 ff 0 0 0
W 6c8 9 2 ff 0 0 0
R 6c8 9 1 ff 0 0 0
W 600 31 1 ff 0 3 4
R 600 31 1 ff 4 0 0
X 650 7 1 c3 3 3 3
R 640 15 1 ff 2 0 0
R 000 255 1 ff 2 0 0

//--- sram_axi_tb.sv
/*
 * SRAM AXI4 slave testbench
 * Replays the stimulus file against the DUT and a shadow memory model
 */
`timescale 1ns/1ps
`include "sram_axi_consts.svh"

module sram_axi_tb;
    import sram_axi_pkg::*;

    logic        aclk;
    logic        areset_n;
    addr_t       araddr;
    len_t        arlen;
    burst_t      arburst;
    logic        arvalid;
    logic        arready;
    logic        rready;
    data_t       rdata;
    logic        rlast;
    logic        rvalid;
    addr_t       awaddr;
    len_t        awlen;
    burst_t      awburst;
    logic        awvalid;
    logic        awready;
    data_t       wdata;
    strb_t       wstrb;
    logic        wvalid;
    logic        wready;
    logic        bready;
    logic        bvalid;

    data_t       shadow [`SRAM_DEPTH];
    logic [15:0] lfsr;
    logic        rd_busy;
    int          limit_cycles;
    int          err_data;
    int          err_last;
    int          err_idx;
    int          err_other;

    // One entry per stimulus line
    byte         op_q[$];
    addr_t       addr_q[$];
    len_t        len_q[$];
    burst_t      burst_q[$];
    strb_t       strb_q[$];
    int          rd_q[$];
    int          bd_q[$];
    int          wd_q[$];

    always #2 aclk = ~aclk;

    sram_axi_top dut_i (
        .i_aclk     (aclk),
        .i_areset_n (areset_n),
        .i_araddr   (araddr),
        .i_arlen    (arlen),
        .i_arburst  (arburst),
        .i_arvalid  (arvalid),
        .o_arready  (arready),
        .i_rready   (rready),
        .o_rdata    (rdata),
        .o_rlast    (rlast),
        .o_rvalid   (rvalid),
        .i_awaddr   (awaddr),
        .i_awlen    (awlen),
        .i_awburst  (awburst),
        .i_awvalid  (awvalid),
        .o_awready  (awready),
        .i_wdata    (wdata),
        .i_wstrb    (wstrb),
        .i_wvalid   (wvalid),
        .o_wready   (wready),
        .i_bready   (bready),
        .o_bvalid   (bvalid)
    );

    bind sram_axi_top sram_axi_checker checker_i (
        .i_aclk     (i_aclk),
        .i_areset_n (i_areset_n),
        .i_arvalid  (i_arvalid),
        .i_awready  (o_awready),
        .i_rvalid   (o_rvalid),
        .i_rready   (i_rready),
        .i_rdata    (o_rdata),
        .i_rlast    (o_rlast),
        .i_wready   (o_wready),
        .i_bvalid   (o_bvalid),
        .i_bready   (i_bready)
    );

    // ====================
    // Random source
    // ====================
    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [63:0] take_bits(int n);
        logic [63:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    // Density in eighths
    function automatic logic stall(int dens);
        return take_bits(3) < 64'(dens);
    endfunction

    // Word index of a beat under the AXI burst rules
    function automatic idx_t beat_idx(addr_t start, len_t len, burst_t burst, int beat);
        int base;
        int win;
        base = int'(start) & ~7;
        if (burst == BURST_FIXED || burst == BURST_RSVD) begin
            return idx_t'(base >> 3);
        end
        if (burst == BURST_WRAP && (len == 8'd1 || len == 8'd3 || len == 8'd7 || len == 8'd15)) begin
            win = (int'(len) + 1) * 8;
            return idx_t'(((base / win) * win + (base % win + beat * 8) % win) >> 3);
        end
        return idx_t'(((base + beat * 8) % (1 << `SRAM_ADDR_W)) >> 3);
    endfunction

    // ====================
    // Compare tasks
    // ====================
    task automatic check_data(string name, data_t exp, data_t act);
        if (exp !== act) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            err_data++;
        end
    endtask

    task automatic check_last(string name, logic exp, logic act);
        if (exp !== act) begin
            $display("Fail %s: expected %b, actual %b", name, exp, act);
            err_last++;
        end
    endtask

    task automatic check_idx(string name, idx_t exp, idx_t act);
        if (exp !== act) begin
            $display("Fail %s: expected %0d, actual %0d", name, exp, act);
            err_idx++;
        end
    endtask

    task automatic load_stim();
        int    fd;
        int    code;
        int    sum;
        byte   op;
        logic [31:0] a;
        logic [31:0] s;
        int    l;
        int    bu;
        int    rd;
        int    bd;
        int    wd;
        string rest;
        sum = 0;
        fd = $fopen("sram_axi_stim.txt", "r");
        if (fd != 0) begin
            code = $fscanf(fd, " %c", op);
            while (code == 1) begin
                if (op == "#") begin
                    code = $fgets(rest, fd);
                end
                else begin
                    code = $fscanf(fd, "%h %d %d %h %d %d %d", a, l, bu, s, rd, bd, wd);
                    op_q.push_back(op);
                    addr_q.push_back(addr_t'(a));
                    len_q.push_back(len_t'(l));
                    burst_q.push_back(burst_t'(bu));
                    strb_q.push_back(strb_t'(s));
                    rd_q.push_back(rd);
                    bd_q.push_back(bd);
                    wd_q.push_back(wd);
                    sum += (l + 1) * 20 + 50;
                end
                code = $fscanf(fd, " %c", op);
            end
            $fclose(fd);
        end
        limit_cycles = sum;
    endtask

    task automatic read_burst(string name, addr_t addr, len_t len, burst_t burst, int dens);
        int   beat;
        logic seen_last;
        idx_t idx;
        rd_busy = 1'b1;
        @(negedge aclk);
        araddr  = addr;
        arlen   = len;
        arburst = burst;
        arvalid = 1'b1;
        #1;
        while (!arready) begin
            @(negedge aclk);
            #1;
        end
        beat = 0;
        seen_last = 1'b0;
        while (!seen_last && beat <= int'(len)) begin
            @(negedge aclk);
            arvalid = 1'b0;
            rready  = !stall(dens);
            #1;
            if (rvalid && rready) begin
                idx = beat_idx(addr, len, burst, beat);
                check_data({name, " data"}, shadow[idx], rdata);
                check_last({name, " last"}, beat == int'(len), rlast);
                seen_last = rlast;
                beat++;
            end
        end
        check_idx({name, " beats"}, idx_t'(len), idx_t'(beat - 1));
        @(negedge aclk);
        rready  = 1'b0;
        rd_busy = 1'b0;
    endtask

    task automatic write_burst(string name, addr_t addr, len_t len, burst_t burst,
                               strb_t strb, int wdens, int bdens);
        data_t data;
        idx_t  idx;
        logic  done;
        logic  first;
        @(negedge aclk);
        awaddr  = addr;
        awlen   = len;
        awburst = burst;
        awvalid = 1'b1;
        #1;
        while (!awready) begin
            @(negedge aclk);
            #1;
        end
        for (int beat = 0; beat <= int'(len); beat++) begin
            data  = take_bits(64);
            done  = 1'b0;
            first = 1'b1;
            while (!done) begin
                @(negedge aclk);
                awvalid = 1'b0;
                // A raised wvalid stays up until taken
                if (first || !wvalid) begin
                    wvalid = !stall(wdens);
                end
                first = 1'b0;
                wdata = data;
                wstrb = strb;
                #1;
                done = wvalid && wready;
            end
            idx = beat_idx(addr, len, burst, beat);
            for (int b = 0; b < `SRAM_BEAT_BYTES; b++) begin
                if (strb[b]) begin
                    shadow[idx][b*8 +: 8] = data[b*8 +: 8];
                end
            end
        end
        done = 1'b0;
        while (!done) begin
            @(negedge aclk);
            wvalid = 1'b0;
            bready = !stall(bdens);
            #1;
            if (bvalid && rd_busy) begin
                $display("Write response of %s arrived before the read finished", name);
                err_other++;
            end
            done = bvalid && bready;
        end
        @(negedge aclk);
        bready = 1'b0;
    endtask

    // Watchdog
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge aclk);
        $display("Watchdog expired after %0d cycles, a transaction never completed",
                 limit_cycles);
        $display("Regression failed");
        $finish;
    end

    initial begin
        string name;
        int    total;
        aclk     = 1'b0;
        areset_n = 1'b0;
        araddr   = '0;
        arlen    = '0;
        arburst  = BURST_INCR;
        arvalid  = 1'b0;
        rready   = 1'b0;
        awaddr   = '0;
        awlen    = '0;
        awburst  = BURST_INCR;
        awvalid  = 1'b0;
        wdata    = '0;
        wstrb    = '0;
        wvalid   = 1'b0;
        bready   = 1'b0;
        lfsr     = 16'd86;
        rd_busy  = 1'b0;
        limit_cycles = 0;
        err_data  = 0;
        err_last  = 0;
        err_idx   = 0;
        err_other = 0;
        for (int i = 0; i < `SRAM_DEPTH; i++) begin
            shadow[i] = data_t'(i);
        end
        load_stim();
        if (op_q.size() == 0) begin
            $display("No transactions could be read from sram_axi_stim.txt");
            $display("Regression failed");
            $finish;
        end
        else begin
            repeat (16) @(posedge aclk);
            @(negedge aclk);
            areset_n = 1'b1;
            for (int i = 0; i < op_q.size(); i++) begin
                name = $sformatf("%c %h len %0d", op_q[i], addr_q[i], len_q[i]);
                case (op_q[i])
                    "R": read_burst(name, addr_q[i], len_q[i], burst_q[i], rd_q[i]);
                    "W": write_burst(name, addr_q[i], len_q[i], burst_q[i], strb_q[i],
                                     wd_q[i], bd_q[i]);
                    "X": begin
                        // AR and AW raised on the same edge
                        fork
                            read_burst(name, addr_q[i], len_q[i], burst_q[i], rd_q[i]);
                            write_burst(name, addr_q[i], len_q[i], burst_q[i], strb_q[i],
                                        wd_q[i], bd_q[i]);
                        join
                    end
                    default: begin
                        $display("Unknown operation in stimulus entry %0d", i + 1);
                        err_other++;
                    end
                endcase
            end
            total = err_data + err_last + err_idx + err_other + dut_i.checker_i.fail_cnt;
            $display("Errors: data %0d, last %0d, beats %0d, other %0d, assertions %0d",
                     err_data, err_last, err_idx, err_other, dut_i.checker_i.fail_cnt);
            if (total == 0) begin
                $display("Regression passed");
            end
            else begin
                $display("Regression failed");
            end
            $finish;
        end
    end

endmodule

//--- sram_axi_top.sv
/*
 * SRAM with AXI4 slave port
 * Connects the controller, read and write ports and the storage array
 */
`timescale 1ns/1ps

module sram_axi_top (
    input  logic                 i_aclk,
    input  logic                 i_areset_n,
    // Read address
    input  sram_axi_pkg::addr_t  i_araddr,
    input  sram_axi_pkg::len_t   i_arlen,
    input  sram_axi_pkg::burst_t i_arburst,
    input  logic                 i_arvalid,
    output logic                 o_arready,
    // Read data
    input  logic                 i_rready,
    output sram_axi_pkg::data_t  o_rdata,
    output logic                 o_rlast,
    output logic                 o_rvalid,
    // Write address
    input  sram_axi_pkg::addr_t  i_awaddr,
    input  sram_axi_pkg::len_t   i_awlen,
    input  sram_axi_pkg::burst_t i_awburst,
    input  logic                 i_awvalid,
    output logic                 o_awready,
    // Write data
    input  sram_axi_pkg::data_t  i_wdata,
    input  sram_axi_pkg::strb_t  i_wstrb,
    input  logic                 i_wvalid,
    output logic                 o_wready,
    // Write response
    input  logic                 i_bready,
    output logic                 o_bvalid
);
    import sram_axi_pkg::*;

    logic  w_rd_start;
    logic  w_wr_start;
    logic  w_rd_done;
    logic  w_wr_done;
    logic  w_mem_rd_en;
    idx_t  w_mem_rd_idx;
    logic  w_mem_wr_en;
    idx_t  w_mem_wr_idx;
    data_t w_mem_wr_data;
    strb_t w_mem_wr_strb;

    sram_axi_ctrl ctrl_i (
        .i_aclk     (i_aclk),
        .i_areset_n (i_areset_n),
        .i_arvalid  (i_arvalid),
        .i_awvalid  (i_awvalid),
        .i_rd_done  (w_rd_done),
        .i_wr_done  (w_wr_done),
        .o_arready  (o_arready),
        .o_awready  (o_awready),
        .o_rd_start (w_rd_start),
        .o_wr_start (w_wr_start)
    );

    sram_axi_read_port read_port_i (
        .i_aclk       (i_aclk),
        .i_areset_n   (i_areset_n),
        .i_rd_start   (w_rd_start),
        .i_araddr     (i_araddr),
        .i_arlen      (i_arlen),
        .i_arburst    (i_arburst),
        .i_rready     (i_rready),
        .o_rvalid     (o_rvalid),
        .o_rlast      (o_rlast),
        .o_rd_done    (w_rd_done),
        .o_mem_rd_en  (w_mem_rd_en),
        .o_mem_rd_idx (w_mem_rd_idx)
    );

    sram_axi_write_port write_port_i (
        .i_aclk        (i_aclk),
        .i_areset_n    (i_areset_n),
        .i_wr_start    (w_wr_start),
        .i_awaddr      (i_awaddr),
        .i_awlen       (i_awlen),
        .i_awburst     (i_awburst),
        .i_wdata       (i_wdata),
        .i_wstrb       (i_wstrb),
        .i_wvalid      (i_wvalid),
        .i_bready      (i_bready),
        .o_wready      (o_wready),
        .o_bvalid      (o_bvalid),
        .o_wr_done     (w_wr_done),
        .o_mem_wr_en   (w_mem_wr_en),
        .o_mem_wr_idx  (w_mem_wr_idx),
        .o_mem_wr_data (w_mem_wr_data),
        .o_mem_wr_strb (w_mem_wr_strb)
    );

    // Registered read data is the R payload
    sram_axi_mem mem_i (
        .i_aclk     (i_aclk),
        .i_areset_n (i_areset_n),
        .i_rd_en    (w_mem_rd_en),
        .i_rd_idx   (w_mem_rd_idx),
        .o_rd_data  (o_rdata),
        .i_wr_en    (w_mem_wr_en),
        .i_wr_idx   (w_mem_wr_idx),
        .i_wr_data  (w_mem_wr_data),
        .i_wr_strb  (w_mem_wr_strb)
    );

endmodule

//--- sram_axi_write_port.sv
/*
 * Write port
 * Turns W beats into byte-masked memory writes and answers on the B channel
 */
`timescale 1ns/1ps

module sram_axi_write_port (
    input  logic                 i_aclk,
    input  logic                 i_areset_n,
    input  logic                 i_wr_start,
    input  sram_axi_pkg::addr_t  i_awaddr,
    input  sram_axi_pkg::len_t   i_awlen,
    input  sram_axi_pkg::burst_t i_awburst,
    input  sram_axi_pkg::data_t  i_wdata,
    input  sram_axi_pkg::strb_t  i_wstrb,
    input  logic                 i_wvalid,
    input  logic                 i_bready,
    output logic                 o_wready,
    output logic                 o_bvalid,
    output logic                 o_wr_done,
    output logic                 o_mem_wr_en,
    output sram_axi_pkg::idx_t   o_mem_wr_idx,
    output sram_axi_pkg::data_t  o_mem_wr_data,
    output sram_axi_pkg::strb_t  o_mem_wr_strb
);
    import sram_axi_pkg::*;

    logic r_wready;
    logic r_bvalid;
    logic w_wshake;
    logic w_bshake;
    logic w_last;

    assign w_wshake = i_wvalid && r_wready;
    assign w_bshake = r_bvalid && i_bready;

    sram_axi_burst_addr wr_addr_i (
        .i_aclk     (i_aclk),
        .i_areset_n (i_areset_n),
        .i_load     (i_wr_start),
        .i_start    (i_awaddr),
        .i_len      (i_awlen),
        .i_burst    (i_awburst),
        .i_step     (w_wshake),
        .o_idx      (o_mem_wr_idx),
        .o_last     (w_last)
    );

    // Beat counter ends the burst, B follows the final beat
    always_ff @(posedge i_aclk) begin
        if (!i_areset_n) begin
            r_wready <= 1'b0;
            r_bvalid <= 1'b0;
        end
        else begin
            if (i_wr_start) begin
                r_wready <= 1'b1;
            end
            else if (w_wshake && w_last) begin
                r_wready <= 1'b0;
            end

            if (w_wshake && w_last) begin
                r_bvalid <= 1'b1;
            end
            else if (w_bshake) begin
                r_bvalid <= 1'b0;
            end
        end
    end

    // Each accepted beat lands in memory at its own edge
    assign o_mem_wr_en   = w_wshake;
    assign o_mem_wr_data = i_wdata;
    assign o_mem_wr_strb = i_wstrb;
    assign o_wready      = r_wready;
    assign o_bvalid      = r_bvalid;
    assign o_wr_done     = w_bshake;

endmodule
